/* sources.f */
+incdir+source
source/txavl_pkg.sv
source/txavl_ctrl.sv
source/rd_split.sv
source/tlp_hdr_gen.sv
source/rd_credit_track.sv
source/msi_req.sv
source/txavl_top.sv
testbench/txavl_asserts.sv
testbench/tb_txavl.sv

/* Makefile */
VERILATOR  := verilator
VFLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_txavl
FILELIST   := sources.f
OBJ_DIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the simulation output holds the pass message
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_txavl.sv */
/*
  directed testbench for the transmit request controller
  models the address translator, the command FIFO and returned read data,
  then runs six tests on reads, splitting, read limits, MSI and back-pressure
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module tb_txavl import txavl_pkg::*;
();

  localparam logic [31:0] SEED = 32'h751d7fc1;
  // rough cycle budget per test: reset, 1 .. 6
  localparam int TEST_CYCLES = 16 + 100 + 600 + 100 + 350 + 150 + 150;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES;

  logic                         AvlClk_i = 1'b0;
  logic                         Rstn_i;
  avl_rd_req_t                  avl_req;
  logic                         tx_wait_request;
  logic                         avl_addr_vld;
  logic [`TXAVL_AVL_ADDR_W-1:0] avl_addr;
  logic                         addr_trans_done = 1'b0;
  logic [63:0]                  pcie_addr = '0;
  logic [1:0]                   pcie_addr_space = '0;
  logic                         cmd_fifo_wr_req;
  tx_req_hdr_t                  cmd_hdr;
  logic [3:0]                   cmd_fifo_usedw;
  logic                         cmd_fifo_busy;
  logic                         txs_read_data_valid = 1'b0;
  txavl_cfg_t                   cfg;
  logic [63:0]                  msi_addr;
  logic [`TXAVL_IRQ_NUM-1:0]    rxm_irq;
  logic                         mb_wr_req;
  logic [2:0]                   mb_wr_addr;

  tx_req_hdr_t got_q[$];
  tx_req_hdr_t exp_q[$];
  int          rdata_budget = 0;
  int          trans_wait = 0;
  int          errors;
  int          tests_passed;
  logic [3:0]  exp_tag;
  logic [31:0] rng_state;

  txavl_top uut (
    .AvlClk_i              (AvlClk_i),
    .Rstn_i                (Rstn_i),
    .avl_req_i             (avl_req),
    .tx_wait_request_o     (tx_wait_request),
    .avl_addr_vld_o        (avl_addr_vld),
    .avl_addr_o            (avl_addr),
    .addr_trans_done_i     (addr_trans_done),
    .pcie_addr_i           (pcie_addr),
    .pcie_addr_space_i     (pcie_addr_space),
    .cmd_fifo_wr_req_o     (cmd_fifo_wr_req),
    .cmd_hdr_o             (cmd_hdr),
    .cmd_fifo_usedw_i      (cmd_fifo_usedw),
    .cmd_fifo_busy_o       (cmd_fifo_busy),
    .txs_read_data_valid_i (txs_read_data_valid),
    .cfg_i                 (cfg),
    .msi_addr_i            (msi_addr),
    .rxm_irq_i             (rxm_irq),
    .mb_wr_req_i           (mb_wr_req),
    .mb_wr_addr_i          (mb_wr_addr)
  );

  bind txavl_ctrl txavl_asserts u_asserts (
    .AvlClk_i   (AvlClk_i),
    .Rstn_i     (Rstn_i),
    .state_i    (state_o),
    .wr_req_i   (cmd_fifo_wr_req_o),
    .usedw_i    (cmd_fifo_usedw_i),
    .msi_pend_i (msi_pend_i)
  );

  always #2 AvlClk_i = ~AvlClk_i;

  // translator: 1_0000_0000 + Avalon address, space 1, answers on the second cycle
  always @(posedge AvlClk_i)
  begin : translator
    logic                         vld_seen;
    logic [`TXAVL_AVL_ADDR_W-1:0] addr_seen;
    vld_seen  = avl_addr_vld;
    addr_seen = avl_addr;
    #0.5;
    if (!vld_seen)
    begin
      trans_wait      = 0;
      addr_trans_done = 1'b0;   // done held until valid falls
    end
    else if (!addr_trans_done)
    begin
      trans_wait = trans_wait + 1;
      if (trans_wait == 2)
      begin
        pcie_addr       = 64'h1_0000_0000 + 64'(addr_seen);
        pcie_addr_space = 2'b01;
        addr_trans_done = 1'b1;
      end
    end
  end

  // command FIFO capture
  always @(posedge AvlClk_i)
  begin
    if (Rstn_i && cmd_fifo_wr_req)
      got_q.push_back(cmd_hdr);
  end

  // one valid pulse per word that a test has released
  always @(posedge AvlClk_i)
  begin
    #0.5;
    if (rdata_budget > 0)
    begin
      txs_read_data_valid = 1'b1;
      rdata_budget        = rdata_budget - 1;
    end
    else
      txs_read_data_valid = 1'b0;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge AvlClk_i);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic step();
    @(posedge AvlClk_i);
    #0.5;
  endtask

  task automatic issue_read(input logic [`TXAVL_AVL_ADDR_W-1:0] addr, input int words,
                            input int max_wait, input bit expect_acc);
    bit accepted;
    int n;
    accepted                = 1'b0;
    n                       = 0;
    avl_req.chip_select     = 1'b1;
    avl_req.read            = 1'b1;
    avl_req.burst_count     = 6'(words);
    avl_req.address         = 28'(addr);
    while (!accepted && n < max_wait)
    begin
      @(posedge AvlClk_i);
      accepted = !tx_wait_request;  // request seen with wait low at this edge
      n++;
      #0.5;
    end
    avl_req = '0;
    assert (accepted == expect_acc)
    else
    begin
      $display("read at %h %s", addr, expect_acc ? "was never accepted" : "was accepted early");
      errors++;
    end
  endtask

  // expected read headers from the min rule
  task automatic expect_read(input logic [`TXAVL_AVL_ADDR_W-1:0] addr, input int words,
                             input int max_bytes);
    tx_req_hdr_t                  h;
    logic [`TXAVL_AVL_ADDR_W-1:0] a;
    int                           remain;
    int                           seg;
    int                           to_4kb;
    a      = addr;
    remain = words * 16;
    while (remain > 0)
    begin
      to_4kb = 4096 - int'(a[11:0]);
      seg    = remain;
      if (max_bytes < seg)
        seg = max_bytes;
      if (to_4kb < seg)
        seg = to_4kb;
      h          = '0;
      h.last_seg = (seg == remain);
      h.lbe      = 4'hF;
      h.len_dw   = 9'(seg / 4);
      h.tag      = exp_tag;
      h.fbe      = 4'hF;
      h.op       = MRD64;
      h.addr     = 64'h1_0000_0000 + 64'(a);
      exp_q.push_back(h);
      exp_tag = exp_tag + 4'h1;
      a       = a + `TXAVL_AVL_ADDR_W'(seg);
      remain  = remain - seg;
    end
  endtask

  task automatic expect_msi(input logic [63:0] addr);
    tx_req_hdr_t h;
    h        = '0;
    h.is_msi = 1'b1;
    h.len_dw = 9'd1;
    h.fbe    = 4'hF;
    h.op     = (addr[63:32] != 32'h0) ? MWR64 : MWR32;
    h.addr   = addr;
    exp_q.push_back(h);
  endtask

  task automatic wait_headers(input int n, input int max_cyc);
    int k;
    k = 0;
    while (got_q.size() < n && k < max_cyc)
    begin
      step();
      k++;
    end
    assert (got_q.size() >= n)
    else
    begin
      $display("timed out waiting for %0d command headers, saw %0d", n, got_q.size());
      errors++;
    end
  endtask

  task automatic check_headers();
    tx_req_hdr_t g;
    tx_req_hdr_t e;
    assert (got_q.size() == exp_q.size())
    else
    begin
      $display("captured %0d headers where %0d were expected", got_q.size(), exp_q.size());
      errors++;
    end
    while (got_q.size() > 0 && exp_q.size() > 0)
    begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      if (e.is_msi)
        e.tag = g.tag;  // tag has no meaning in an MSI write
      assert (g == e)
      else
      begin
        $display("ERROR cmd_hdr_o got %h expected %h", g, e);
        errors++;
      end
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // all data back and the DUT open for reads again
  task automatic drain();
    int k;
    bit busy;
    k    = 0;
    busy = 1'b1;
    while (busy && k < 200)
    begin
      @(posedge AvlClk_i);
      busy = (rdata_budget > 0) || tx_wait_request;
      k++;
      #0.5;
    end
    assert (!busy)
    else
    begin
      $display("DUT did not return to idle with read slots free");
      errors++;
    end
    repeat (4) step();  // last retire
  endtask

  task automatic report_test(input int num, input string name, input int err_before);
    if (errors == err_before)
    begin
      tests_passed++;
      $display("test %0d %s: ok", num, name);
    end
    else
      $display("test %0d %s: %0d error(s)", num, name, errors - err_before);
  endtask

  task automatic test_single_read();
    int e0;
    e0 = errors;
    assert (!cmd_fifo_wr_req && !avl_addr_vld && !cmd_fifo_busy)
    else
    begin
      $display("ERROR after reset cmd_fifo_wr_req_o=%h avl_addr_vld_o=%h cmd_fifo_busy_o=%h",
               cmd_fifo_wr_req, avl_addr_vld, cmd_fifo_busy);
      errors++;
    end
    cfg.max_rd_code = 3'd2;
    expect_read(20'h01230, 4, 512);
    issue_read(20'h01230, 4, 20, 1'b1);
    wait_headers(1, 50);
    check_headers();
    rdata_budget += 4;
    drain();
    report_test(1, "single read", e0);
  endtask

  task automatic test_max_read_split();
    int                           e0;
    int                           words;
    int                           n;
    logic [`TXAVL_AVL_ADDR_W-1:0] addr;
    e0              = errors;
    cfg.max_rd_code = 3'd0;  // 128 bytes
    repeat (6)
    begin
      rng_state = next_random(rng_state);
      words     = int'(rng_state[4:0]) + 1;
      addr      = {rng_state[24:9], 4'h0};
      expect_read(addr, words, 128);
      n = exp_q.size();
      issue_read(addr, words, 20, 1'b1);
      wait_headers(n, 40 * n);
      check_headers();
      rdata_budget += words;
    end
    drain();
    report_test(2, "max read split", e0);
  endtask

  task automatic test_4kb_split();
    int e0;
    e0              = errors;
    cfg.max_rd_code = 3'd2;
    expect_read(20'h00FC0, 8, 512);  // 64 bytes, then 64 from 0x1000
    issue_read(20'h00FC0, 8, 20, 1'b1);
    wait_headers(2, 80);
    check_headers();
    rdata_budget += 8;
    drain();
    report_test(3, "4 KB crossing", e0);
  endtask

  task automatic test_outstanding_limit();
    int e0;
    int rest;
    e0   = errors;
    rest = 0;
    for (int i = 0; i < `TXAVL_MAX_OUTSTANDING; i++)
    begin
      expect_read(20'h10000 + 20'(i * 256), i + 1, 512);
      issue_read(20'h10000 + 20'(i * 256), i + 1, 20, 1'b1);
      wait_headers(i + 1, 40);
      if (i > 0)
        rest += i + 1;
    end
    issue_read(20'h18000, 2, 30, 1'b0);  // ninth held off
    rdata_budget += 1;                   // first read had one word
    expect_read(20'h18000, 2, 512);
    issue_read(20'h18000, 2, 40, 1'b1);
    wait_headers(`TXAVL_MAX_OUTSTANDING + 1, 40);
    check_headers();
    rdata_budget += rest + 2;
    drain();
    report_test(4, "outstanding limit", e0);
  endtask

  task automatic test_msi();
    int e0;
    e0            = errors;
    cfg.msi_en    = 1'b1;
    cfg.irq_ena   = 32'h0020_0001;  // irq line 0 and mailbox slot 5
    msi_addr      = 64'h0000_0000_FEE0_1000;
    expect_msi(msi_addr);
    rxm_irq = 1'b1;
    wait_headers(1, 20);
    rxm_irq = 1'b0;
    check_headers();
    msi_addr = 64'h0000_0002_FEE0_2000;
    expect_msi(msi_addr);
    expect_read(20'h20000, 2, 512);
    mb_wr_addr = 3'd5;
    mb_wr_req  = 1'b1;
    step();
    mb_wr_req = 1'b0;
    assert (cmd_fifo_busy)
    else
    begin
      $display("ERROR cmd_fifo_busy_o=%h with an MSI pending", cmd_fifo_busy);
      errors++;
    end
    issue_read(20'h20000, 2, 20, 1'b1);  // waits behind the MSI
    wait_headers(2, 50);
    check_headers();
    rdata_budget += 2;
    mb_wr_addr = 3'd3;                   // slot not enabled
    mb_wr_req  = 1'b1;
    step();
    mb_wr_req = 1'b0;
    repeat (10) step();
    assert (got_q.size() == 0)
    else
    begin
      $display("a write to a disabled mailbox slot produced a header");
      errors++;
    end
    got_q.delete();
    cfg.msi_en = 1'b0;
    drain();
    report_test(5, "MSI insertion", e0);
  endtask

  task automatic test_fifo_backpressure();
    int e0;
    e0              = errors;
    cfg.max_rd_code = 3'd0;
    cmd_fifo_usedw  = 4'(`TXAVL_CMD_FIFO_LIMIT + 1);
    expect_read(20'h30000, 16, 128);
    issue_read(20'h30000, 16, 20, 1'b1);
    repeat (30) step();
    assert (got_q.size() == 0)
    else
    begin
      $display("header written while the command FIFO was above its limit");
      errors++;
    end
    assert (avl_addr_vld)
    else
    begin
      $display("ERROR avl_addr_vld_o=%h while held by a full command FIFO", avl_addr_vld);
      errors++;
    end
    cmd_fifo_usedw = 4'd3;
    wait_headers(2, 60);
    check_headers();
    rdata_budget += 16;
    drain();
    report_test(6, "command FIFO back-pressure", e0);
  endtask

  initial
  begin
    Rstn_i          = 1'b0;
    avl_req         = '0;
    cmd_fifo_usedw  = 4'd0;
    cfg             = '0;
    cfg.master_en   = 1'b1;
    cfg.max_rd_code = 3'd2;
    msi_addr        = '0;
    rxm_irq         = '0;
    mb_wr_req       = 1'b0;
    mb_wr_addr      = 3'd0;
    errors          = 0;
    tests_passed    = 0;
    exp_tag         = 4'h0;
    rng_state       = SEED;
    repeat (16) @(posedge AvlClk_i);
    #0.5;
    Rstn_i = 1'b1;
    test_single_read();
    test_max_read_split();
    test_4kb_split();
    test_outstanding_limit();
    test_msi();
    test_fifo_backpressure();
    $display("summary: %0d of 6 tests passed, %0d errors", tests_passed, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

/* testbench/txavl_asserts.sv */
/*
  concurrent checks on the read and MSI control FSM
  bound to txavl_ctrl from the testbench
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module txavl_asserts import txavl_pkg::*;
(
  input logic         AvlClk_i,
  input logic         Rstn_i,
  input txavl_state_e state_i,
  input logic         wr_req_i,
  input logic [3:0]   usedw_i,
  input logic         msi_pend_i
);

  state_one_hot: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    $onehot(state_i))
    else $error("control state %b is not one-hot", state_i);

  // each header write is a single cycle strobe
  wr_req_pulse: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    wr_req_i |=> !wr_req_i)
    else $error("cmd_fifo_wr_req_o held high for more than one cycle");

  // level was checked in the cycle that decided the write
  wr_under_limit: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    wr_req_i |-> ($past(usedw_i) <= 4'(`TXAVL_CMD_FIFO_LIMIT)))
    else $error("header written with command FIFO level %0d", $past(usedw_i));

  // a read never starts while an MSI waits in IDLE
  msi_before_rd: assert property (@(posedge AvlClk_i) disable iff (!Rstn_i)
    msi_pend_i && (state_i == IDLE) |=> (state_i != WAIT_RDADDR))
    else $error("read accepted ahead of a pending MSI");

endmodule

/* source/txavl_top.sv */
/*
  Avalon to PCIe transmit request controller, read and MSI side
  connects the control FSM, the segment sizer, the header builder,
  the outstanding read tracker and the MSI request flag
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module txavl_top import txavl_pkg::*;
(
  input  logic                         AvlClk_i,
  input  logic                         Rstn_i,
  input  avl_rd_req_t                  avl_req_i,
  output logic                         tx_wait_request_o,
  output logic                         avl_addr_vld_o,
  output logic [`TXAVL_AVL_ADDR_W-1:0] avl_addr_o,
  input  logic                         addr_trans_done_i,
  input  logic [63:0]                  pcie_addr_i,
  input  logic [1:0]                   pcie_addr_space_i,
  output logic                         cmd_fifo_wr_req_o,
  output tx_req_hdr_t                  cmd_hdr_o,
  input  logic [3:0]                   cmd_fifo_usedw_i,
  output logic                         cmd_fifo_busy_o,
  input  logic                         txs_read_data_valid_i,
  input  txavl_cfg_t                   cfg_i,
  input  logic [63:0]                  msi_addr_i,
  input  logic [`TXAVL_IRQ_NUM-1:0]    rxm_irq_i,
  input  logic                         mb_wr_req_i,
  input  logic [2:0]                   mb_wr_addr_i
);

  txavl_state_e state;
  logic         rd_accept;
  logic         rd_slot_avail;
  logic         last_seg;
  logic         msi_pend;
  logic [9:0]   seg_bytes;

  txavl_ctrl u_ctrl (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .avl_req_i         (avl_req_i),
    .cfg_i             (cfg_i),
    .addr_trans_done_i (addr_trans_done_i),
    .cmd_fifo_usedw_i  (cmd_fifo_usedw_i),
    .rd_slot_avail_i   (rd_slot_avail),
    .last_seg_i        (last_seg),
    .msi_pend_i        (msi_pend),
    .state_o           (state),
    .rd_accept_o       (rd_accept),
    .tx_wait_request_o (tx_wait_request_o),
    .avl_addr_vld_o    (avl_addr_vld_o),
    .cmd_fifo_wr_req_o (cmd_fifo_wr_req_o),
    .cmd_fifo_busy_o   (cmd_fifo_busy_o)
  );

  rd_split u_rd_split (
    .AvlClk_i      (AvlClk_i),
    .Rstn_i        (Rstn_i),
    .state_i       (state),
    .avl_req_i     (avl_req_i),
    .max_rd_code_i (cfg_i.max_rd_code),
    .avl_addr_o    (avl_addr_o),
    .seg_bytes_o   (seg_bytes),
    .last_seg_o    (last_seg)
  );

  tlp_hdr_gen u_hdr_gen (
    .AvlClk_i          (AvlClk_i),
    .Rstn_i            (Rstn_i),
    .state_i           (state),
    .addr_trans_done_i (addr_trans_done_i),
    .pcie_addr_i       (pcie_addr_i),
    .pcie_addr_space_i (pcie_addr_space_i),
    .seg_bytes_i       (seg_bytes),
    .last_seg_i        (last_seg),
    .msi_addr_i        (msi_addr_i),
    .cmd_hdr_o         (cmd_hdr_o)
  );

  rd_credit_track u_credit (
    .AvlClk_i              (AvlClk_i),
    .Rstn_i                (Rstn_i),
    .rd_accept_i           (rd_accept),
    .burst_count_i         (avl_req_i.burst_count),
    .txs_read_data_valid_i (txs_read_data_valid_i),
    .rd_slot_avail_o       (rd_slot_avail)
  );

  msi_req u_msi (
    .AvlClk_i     (AvlClk_i),
    .Rstn_i       (Rstn_i),
    .state_i      (state),
    .rxm_irq_i    (rxm_irq_i),
    .cfg_i        (cfg_i),
    .mb_wr_req_i  (mb_wr_req_i),
    .mb_wr_addr_i (mb_wr_addr_i),
    .msi_pend_o   (msi_pend)
  );

endmodule

/* source/msi_req.sv */
/*
  MSI request flag
  set by a rising edge on an enabled interrupt line or by a write to an
  enabled mailbox slot, both only when MSI is enabled
  cleared once the control FSM passes through its MSI state
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module msi_req import txavl_pkg::*;
(
  input  logic                      AvlClk_i,
  input  logic                      Rstn_i,
  input  txavl_state_e              state_i,
  input  logic [`TXAVL_IRQ_NUM-1:0] rxm_irq_i,
  input  txavl_cfg_t                cfg_i,
  input  logic                      mb_wr_req_i,
  input  logic [2:0]                mb_wr_addr_i,
  output logic                      msi_pend_o
);

  logic [`TXAVL_IRQ_NUM-1:0] irq_act;
  logic                      irq_q;
  logic                      irq_rise;
  logic [7:0]                mb_slot_ena;
  logic                      mb_hit;
  logic                      pend_set;
  logic                      pend_q;

  assign irq_act  = rxm_irq_i & cfg_i.irq_ena[`TXAVL_IRQ_NUM-1:0];
  assign irq_rise = (|irq_act) & ~irq_q;

  assign mb_slot_ena = cfg_i.irq_ena[23:16];   // one enable per mailbox slot
  assign mb_hit      = mb_wr_req_i & mb_slot_ena[mb_wr_addr_i];

  assign pend_set = (irq_rise | mb_hit) & cfg_i.msi_en;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      irq_q  <= 1'b0;
      pend_q <= 1'b0;
    end
    else
    begin
      irq_q <= |irq_act;
      if (pend_set)
        pend_q <= 1'b1;   // a new event wins over the clear
      else if (state_i == MSI)
        pend_q <= 1'b0;
    end
  end

  assign msi_pend_o = pend_q;

endmodule

/* source/rd_credit_track.sv */
/*
  outstanding read tracking
  each accepted read pushes its burst count into a small register FIFO;
  the head is loaded and returned data valid pulses are counted against it
  a read retires when its count is reached, freeing one read slot
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module rd_credit_track import txavl_pkg::*;
(
  input  logic                      AvlClk_i,
  input  logic                      Rstn_i,
  input  logic                      rd_accept_i,
  input  logic [`TXAVL_BURST_W-1:0] burst_count_i,
  input  logic                      txs_read_data_valid_i,
  output logic                      rd_slot_avail_o
);

  localparam int PTR_W = $clog2(`TXAVL_PEND_DEPTH);
  localparam int CNT_W = $clog2(`TXAVL_MAX_OUTSTANDING + 1);

  logic [`TXAVL_BURST_W-1:0] pend_mem [`TXAVL_PEND_DEPTH];
  logic [PTR_W:0]            wr_ptr_q;
  logic [PTR_W:0]            rd_ptr_q;
  logic [`TXAVL_BURST_W-1:0] fifo_q;      // FIFO read register
  logic [`TXAVL_BURST_W-1:0] head_q;
  logic                      fifo_empty;
  logic                      fifo_pop;
  pend_state_e               pend_state_q;
  pend_state_e               pend_state_d;
  logic [`TXAVL_BURST_W:0]   valid_cnt_q;
  logic                      retire;
  logic [CNT_W-1:0]          rd_out_q;

  assign fifo_empty = (wr_ptr_q == rd_ptr_q);
  assign retire     = (pend_state_q == PEND_CHECK) & (valid_cnt_q >= {1'b0, head_q});
  assign fifo_pop   = ~fifo_empty & ((pend_state_q == PEND_IDLE) | retire);

  always_ff @(posedge AvlClk_i)
  begin
    if (rd_accept_i)
      pend_mem[wr_ptr_q[PTR_W-1:0]] <= burst_count_i;
    if (fifo_pop)
      fifo_q <= pend_mem[rd_ptr_q[PTR_W-1:0]];
    if (pend_state_q == PEND_LATCH)
      head_q <= fifo_q;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      pend_state_q <= PEND_IDLE;
    end
    else
    begin
      pend_state_q <= pend_state_d;
      if (rd_accept_i)
        wr_ptr_q <= wr_ptr_q + 1'b1;
      if (fifo_pop)
        rd_ptr_q <= rd_ptr_q + 1'b1;
    end
  end

  always_comb
  begin
    pend_state_d = pend_state_q;
    case (pend_state_q)
      PEND_IDLE:  if (!fifo_empty) pend_state_d = PEND_LATCH;
      PEND_LATCH: pend_state_d = PEND_CHECK;
      PEND_CHECK:
      begin
        if (retire)
          pend_state_d = fifo_empty ? PEND_IDLE : PEND_LATCH;
      end
      default:    pend_state_d = PEND_IDLE;
    endcase
  end

  // surplus pulses already belong to the next read, so carry them over
  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      valid_cnt_q <= '0;
    else if (retire)
      valid_cnt_q <= valid_cnt_q - {1'b0, head_q} +
                     {{`TXAVL_BURST_W{1'b0}}, txs_read_data_valid_i};
    else if (txs_read_data_valid_i)
      valid_cnt_q <= valid_cnt_q + 1'b1;
  end

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      rd_out_q <= '0;
    else if (rd_accept_i & ~retire)
      rd_out_q <= rd_out_q + 1'b1;
    else if (retire & ~rd_accept_i)
      rd_out_q <= rd_out_q - 1'b1;
  end

  assign rd_slot_avail_o = (rd_out_q < CNT_W'(`TXAVL_MAX_OUTSTANDING));

endmodule

/* source/tlp_hdr_gen.sv */
/*
  request header assembly for the command FIFO
  latches the translated PCIe address on the rising edge of done, keeps
  the rolling read tag and builds either a read header or an MSI write
  header from the current control state
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module tlp_hdr_gen import txavl_pkg::*;
(
  input  logic         AvlClk_i,
  input  logic         Rstn_i,
  input  txavl_state_e state_i,
  input  logic         addr_trans_done_i,
  input  logic [63:0]  pcie_addr_i,
  input  logic [1:0]   pcie_addr_space_i,
  input  logic [9:0]   seg_bytes_i,
  input  logic         last_seg_i,
  input  logic [63:0]  msi_addr_i,
  output tx_req_hdr_t  cmd_hdr_o
);

  logic        done_q;
  logic        done_rise;
  logic [63:0] pcie_addr_q;
  logic        space_64_q;
  logic [3:0]  tag_q;
  logic        rd_64;
  logic        msi_64;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
    begin
      done_q <= 1'b0;
      tag_q  <= 4'h0;
    end
    else
    begin
      done_q <= addr_trans_done_i;
      if (state_i == RDHEADER)
        tag_q <= tag_q + 4'h1;  // wraps at 16
    end
  end

  assign done_rise = addr_trans_done_i & ~done_q;

  // one translation per segment
  always_ff @(posedge AvlClk_i)
  begin
    if (done_rise)
    begin
      pcie_addr_q <= pcie_addr_i;
      space_64_q  <= pcie_addr_space_i[0];
    end
  end

  assign rd_64  = space_64_q & (pcie_addr_q[63:32] != 32'h0);
  assign msi_64 = (msi_addr_i[63:32] != 32'h0);

  always_comb
  begin
    cmd_hdr_o     = '0;
    cmd_hdr_o.tag = tag_q;
    cmd_hdr_o.fbe = 4'hF;
    if (state_i == MSI)
    begin
      cmd_hdr_o.is_msi = 1'b1;
      cmd_hdr_o.op     = msi_64 ? MWR64 : MWR32;
      cmd_hdr_o.len_dw = 9'd1;   // single DW, lbe stays 0
      cmd_hdr_o.addr   = msi_addr_i;
    end
    else
    begin
      cmd_hdr_o.last_seg = (state_i == RDHEADER) & last_seg_i;
      cmd_hdr_o.lbe      = 4'hF;
      cmd_hdr_o.len_dw   = {1'b0, seg_bytes_i[9:2]};
      cmd_hdr_o.op       = rd_64 ? MRD64 : MRD32;
      cmd_hdr_o.addr     = pcie_addr_q;
    end
  end

endmodule

/* source/rd_split.sv */
/*
  read segment sizing
  holds the byte address and the remaining byte count of the current read
  and picks each segment as the smallest of remaining bytes, max read
  request size and bytes left to the next 4 KB boundary
  the three-way select is registered, so sizes settle one cycle after a move
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module rd_split import txavl_pkg::*;
(
  input  logic                         AvlClk_i,
  input  logic                         Rstn_i,
  input  txavl_state_e                 state_i,
  input  avl_rd_req_t                  avl_req_i,
  input  logic [2:0]                   max_rd_code_i,
  output logic [`TXAVL_AVL_ADDR_W-1:0] avl_addr_o,
  output logic [9:0]                   seg_bytes_o,
  output logic                         last_seg_o
);

  logic [`TXAVL_AVL_ADDR_W-1:0] addr_q;
  logic [9:0]                   remain_q;
  logic [9:0]                   max_rd_size;
  logic [12:0]                  bytes_to_4kb;
  logic                         to_4kb_sel;
  logic                         remain_sel;
  logic [1:0]                   size_sel_q;

  always_comb
  begin
    case (max_rd_code_i)
      3'b000:  max_rd_size = 10'd128;
      3'b001:  max_rd_size = 10'd256;
      default: max_rd_size = 10'd512;  // larger codes capped
    endcase
  end

  // loaded on every idle cycle, the last load is the accepted read
  always_ff @(posedge AvlClk_i)
  begin
    if (state_i == IDLE)
    begin
      addr_q   <= {avl_req_i.address[`TXAVL_AVL_ADDR_W-1:4], 4'h0};
      remain_q <= {avl_req_i.burst_count, 4'h0}; // 16 bytes per word
    end
    else if (state_i == RDHEADER)
    begin
      addr_q   <= addr_q + {{(`TXAVL_AVL_ADDR_W-10){1'b0}}, seg_bytes_o};
      remain_q <= remain_q - seg_bytes_o;
    end
  end

  assign bytes_to_4kb = 13'h1000 - {1'b0, addr_q[11:0]};

  assign to_4kb_sel = ({3'b000, max_rd_size} >= bytes_to_4kb) &
                      ({3'b000, remain_q} > bytes_to_4kb);
  assign remain_sel = (remain_q <= max_rd_size) &
                      ({3'b000, remain_q} <= bytes_to_4kb);

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      size_sel_q <= 2'b00;
    else
      size_sel_q <= {to_4kb_sel, remain_sel};
  end

  always_comb
  begin
    case (size_sel_q)
      2'b01:   seg_bytes_o = remain_q;
      2'b10:   seg_bytes_o = bytes_to_4kb[9:0];  // never above 512 here
      default: seg_bytes_o = max_rd_size;
    endcase
  end

  assign last_seg_o = (size_sel_q == 2'b01);
  assign avl_addr_o = addr_q;

endmodule

/* source/txavl_ctrl.sv */
/*
  read and MSI control for the transmit request path
  one-hot FSM that accepts an Avalon burst read, waits for the address
  translator and writes one command FIFO header per read segment
  a pending MSI is taken from IDLE ahead of any new read
*/
`timescale 1ns/100ps
`include "txavl_defines.svh"

module txavl_ctrl import txavl_pkg::*;
(
  input  logic         AvlClk_i,
  input  logic         Rstn_i,
  input  avl_rd_req_t  avl_req_i,
  input  txavl_cfg_t   cfg_i,
  input  logic         addr_trans_done_i,
  input  logic [3:0]   cmd_fifo_usedw_i,
  input  logic         rd_slot_avail_i,
  input  logic         last_seg_i,
  input  logic         msi_pend_i,
  output txavl_state_e state_o,
  output logic         rd_accept_o,
  output logic         tx_wait_request_o,
  output logic         avl_addr_vld_o,
  output logic         cmd_fifo_wr_req_o,
  output logic         cmd_fifo_busy_o
);

  txavl_state_e state_q;
  txavl_state_e state_d;
  logic         cmd_fifo_ok;
  logic         rd_ready;
  logic         msi_go;

  assign cmd_fifo_ok = (cmd_fifo_usedw_i <= 4'(`TXAVL_CMD_FIFO_LIMIT));

  // a read waits while an MSI is pending or done is still held from the last one
  assign rd_ready = (state_q == IDLE) & cfg_i.master_en & rd_slot_avail_i &
                    ~msi_pend_i & ~addr_trans_done_i;
  assign msi_go   = msi_pend_i & cfg_i.master_en & cmd_fifo_ok;

  assign rd_accept_o       = rd_ready & avl_req_i.chip_select & avl_req_i.read;
  assign tx_wait_request_o = ~rd_ready;

  always_ff @(posedge AvlClk_i or negedge Rstn_i)
  begin
    if (!Rstn_i)
      state_q <= IDLE;
    else
      state_q <= state_d;
  end

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (msi_go)
          state_d = MSI;          // MSI first
        else if (rd_accept_o)
          state_d = WAIT_RDADDR;
      end
      WAIT_RDADDR:
      begin
        if (addr_trans_done_i & cmd_fifo_ok)
          state_d = RDHEADER;
      end
      RDHEADER:
      begin
        if (last_seg_i)
          state_d = IDLE;
        else
          state_d = RDPIPE;
      end
      RDPIPE:
      begin
        // let the translator drop done before asking for the next segment
        if (!addr_trans_done_i)
          state_d = WAIT_RDADDR;
      end
      MSI:     state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  assign state_o           = state_q;
  assign avl_addr_vld_o    = (state_q == WAIT_RDADDR);
  assign cmd_fifo_wr_req_o = (state_q == RDHEADER) | (state_q == MSI);
  assign cmd_fifo_busy_o   = (state_q == WAIT_RDADDR) | msi_pend_i; // one cycle ahead of the write

endmodule

/* source/txavl_pkg.sv */
/*
  types shared by the transmit request controller blocks
  state and opcode enums, the Avalon read request, the configuration
  bundle and the command FIFO entry; import with txavl_pkg::*
*/
`include "txavl_defines.svh"

package txavl_pkg;

  // control FSM, one-hot
  typedef enum logic [4:0] {
    IDLE        = 5'b00001,
    WAIT_RDADDR = 5'b00010,
    RDHEADER    = 5'b00100,
    RDPIPE      = 5'b01000,
    MSI         = 5'b10000
  } txavl_state_e;

  // outstanding read tracker FSM
  typedef enum logic [1:0] {
    PEND_IDLE  = 2'd0,
    PEND_LATCH = 2'd1,
    PEND_CHECK = 2'd2
  } pend_state_e;

  typedef enum logic [1:0] {
    MRD32 = 2'd0,
    MRD64 = 2'd1,
    MWR32 = 2'd2,
    MWR64 = 2'd3
  } req_op_e;

  typedef struct packed {
    logic                      chip_select;
    logic                      read;
    logic [`TXAVL_BURST_W-1:0] burst_count;
    logic [27:0]               address;      // byte address
  } avl_rd_req_t;

  typedef struct packed {
    logic [2:0]  max_rd_code;  // max read request field of device control
    logic        master_en;
    logic        msi_en;
    logic [31:0] irq_ena;      // low bits irq lines, 23:16 mailbox slots
  } txavl_cfg_t;

  // command FIFO entry, 110 bits
  typedef struct packed {
    logic        last_seg;
    logic [3:0]  lbe;
    logic [8:0]  len_dw;
    logic        is_msi;
    logic [3:0]  tag;
    logic [3:0]  fbe;
    req_op_e     op;
    logic [63:0] addr;
    logic [20:0] pad;
  } tx_req_hdr_t;

endpackage

/* source/txavl_defines.svh */
/*
  width and limit macros for the Avalon to PCIe transmit request controller
  include in every RTL file that needs a width or a limit; the include guard
  keeps repeated inclusion harmless
*/
`ifndef TXAVL_DEFINES_SVH
`define TXAVL_DEFINES_SVH

// Avalon slave side
`define TXAVL_AVL_ADDR_W       20  // byte address bits used by the controller
`define TXAVL_BURST_W          6   // burst count in 128-bit words

// interrupt inputs
`define TXAVL_IRQ_NUM          1

// read flow control
`define TXAVL_MAX_OUTSTANDING  8   // reads in flight before wait request holds
`define TXAVL_PEND_DEPTH       16  // pending-burst FIFO entries

// command FIFO fill level above which no header is written
`define TXAVL_CMD_FIFO_LIMIT   8

`endif
